// ==== frame_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ip_udp_config.svh"

module frame_sequencer (
	input  wire logic                     clk,
	input  wire logic                     reset_n,
	input  wire ip_udp_pkg::beat_t        beat_i,
	input  wire logic                     vld_i,
	input  wire logic                     vld_pre_i,
	input  wire ip_udp_pkg::hdr_fields_t  hdr_i,
	output logic                          pipe_ready_o,
	output logic [`IPU_DATA_W-1:0]        ip_udp_tdata_o,
	output logic [`IPU_KEEP_W-1:0]        ip_udp_tkeep_o,
	output logic                          ip_udp_tlast_o,
	output logic                          ip_udp_tvld_o,
	input  wire logic                     ip_udp_rdy_i
);

	import ip_udp_pkg::*;

	// state names the word loaded on the next ready cycle
	typedef enum logic [3:0] {
		IDLE,
		S_IP_LEN,
		S_IP_ID,
		S_IP_CSUM,
		S_IP_SRC,
		S_IP_DST,
		S_UDP_PORTS,
		S_UDP_LEN,
		S_PAYLOAD
	} state_t;

	state_t                 state_q, state_d;
	logic [`IPU_DATA_W-1:0] word_d;
	logic [`IPU_KEEP_W-1:0] keep_d;
	logic                   last_d;
	logic                   vld_d;

	// header states keep the pipe frozen on the current packet
	assign pipe_ready_o = !vld_i || (state_q == S_PAYLOAD && ip_udp_rdy_i);

	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE:        if (vld_i && ip_udp_rdy_i) state_d = S_IP_ID; // word 0 loads here
			S_IP_LEN:    if (ip_udp_rdy_i) state_d = S_IP_ID;
			S_IP_ID:     if (ip_udp_rdy_i) state_d = S_IP_CSUM;
			S_IP_CSUM:   if (ip_udp_rdy_i) state_d = S_IP_SRC;
			S_IP_SRC:    if (ip_udp_rdy_i) state_d = S_IP_DST;
			S_IP_DST:    if (ip_udp_rdy_i) state_d = S_UDP_PORTS;
			S_UDP_PORTS: if (ip_udp_rdy_i) state_d = S_UDP_LEN;
			S_UDP_LEN:   if (ip_udp_rdy_i) state_d = S_PAYLOAD;
			S_PAYLOAD: begin
				if (ip_udp_rdy_i && vld_i && beat_i.last)
					state_d = vld_pre_i ? S_IP_LEN : IDLE; // back-to-back packet
			end
			default:     state_d = IDLE;
		endcase
	end

	// word for the output register
	always_comb begin
		word_d = '0;
		keep_d = '1;    // header words are full
		last_d = 1'b0;
		vld_d  = 1'b1;
		case (state_q)
			IDLE, S_IP_LEN: begin
				word_d = {hdr_i.ip_ver_tos, hdr_i.ip_total_len};
				vld_d  = vld_i;  // always set in S_IP_LEN
			end
			S_IP_ID:     word_d = {hdr_i.ip_ident, hdr_i.ip_flags_frag};
			S_IP_CSUM:   word_d = {hdr_i.ip_ttl_proto, hdr_i.ip_csum};
			S_IP_SRC:    word_d = hdr_i.ip_src;
			S_IP_DST:    word_d = hdr_i.ip_dst;
			S_UDP_PORTS: word_d = {hdr_i.port_src, hdr_i.port_dst};
			S_UDP_LEN:   word_d = {hdr_i.udp_len, hdr_i.udp_csum};
			S_PAYLOAD: begin
				word_d = beat_i.data;
				keep_d = beat_i.keep;
				last_d = vld_i && beat_i.last;
				vld_d  = vld_i;  // bubble while the pipe refills
			end
			default:     vld_d = 1'b0;
		endcase
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			state_q        <= IDLE;
			ip_udp_tvld_o  <= 1'b0;
			ip_udp_tlast_o <= 1'b0;
		end else begin
			state_q <= state_d;
			if (ip_udp_rdy_i) begin  // hold everything under back-pressure
				ip_udp_tvld_o  <= vld_d;
				ip_udp_tlast_o <= last_d;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ip_udp_rdy_i) begin
			ip_udp_tdata_o <= word_d;
			ip_udp_tkeep_o <= keep_d;
		end
	end

endmodule

`default_nettype wire

// ==== header_csum_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ip_udp_config.svh"

module header_csum_pipe (
	input  wire logic                  clk,
	input  wire logic                  reset_n,
	input  wire ip_udp_pkg::beat_t     beat_i,
	input  wire ip_udp_pkg::pkt_info_t info_i,
	input  wire logic                  vld_i,
	output logic                       adv_o,
	output ip_udp_pkg::beat_t          beat_o,
	output logic                       vld_o,
	output logic                       vld_pre_o,
	output ip_udp_pkg::hdr_fields_t    hdr_o,
	input  wire logic                  pipe_ready_i
);

	import ip_udp_pkg::*;

	beat_t       beat_q [1:5];
	pkt_info_t   info_q [1:5];
	logic [15:0] ulen_q [1:5];  // udp length
	logic [15:0] ilen_q [1:5];  // ip total length
	logic [5:1]  vld_q;

	// udp tree, level 0 in stage 2
	logic [15:0] u0_q, u1_q, u2_q, u3_q, u4_q;
	logic [15:0] u10_q, u11_q, u12_q;
	logic [15:0] u20_q, u21_q;
	// ip tree runs alongside
	logic [15:0] i0_q, i1_q, i2_q;
	logic [15:0] i10_q, i11_q;
	logic [15:0] i20_q;
	logic [15:0] udp_csum_q, ip_csum_q;

	// whole pipe freezes together
	assign adv_o = pipe_ready_i;

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n)
			vld_q <= '0;
		else if (pipe_ready_i)
			vld_q <= {vld_q[4:1], vld_i};
	end

	always_ff @(posedge clk) begin
		if (pipe_ready_i) begin
			// stage 1 lengths
			beat_q[1] <= beat_i;
			info_q[1] <= info_i;
			ulen_q[1] <= info_i.byte_cnt + 16'(`IPU_UDP_HDR_BYTES);
			ilen_q[1] <= info_i.byte_cnt + 16'(`IPU_UDP_HDR_BYTES + `IPU_IP_HDR_BYTES);
			for (int s = 2; s <= 5; s++) begin // delay line for beat and fields
				beat_q[s] <= beat_q[s-1];
				info_q[s] <= info_q[s-1];
				ulen_q[s] <= ulen_q[s-1];
				ilen_q[s] <= ilen_q[s-1];
			end

			// stage 2 pseudo-header, ports, length, payload
			u0_q <= csum_add(info_q[1].ip_src[31:16], info_q[1].ip_src[15:0]);
			u1_q <= csum_add(info_q[1].ip_dst[31:16], info_q[1].ip_dst[15:0]);
			u2_q <= csum_add(ulen_q[1], 16'(`IPU_PROTO_UDP)); // {zero, proto} + len
			u3_q <= csum_add(info_q[1].port_src, info_q[1].port_dst);
			u4_q <= csum_add(ulen_q[1], info_q[1].data_sum);  // udp hdr length word
			// ident and frag are zero, only the fixed words plus length
			i0_q <= csum_add(csum_add(`IPU_VER_TOS, `IPU_TTL_PROTO), ilen_q[1]);
			i1_q <= csum_add(info_q[1].ip_src[31:16], info_q[1].ip_src[15:0]);
			i2_q <= csum_add(info_q[1].ip_dst[31:16], info_q[1].ip_dst[15:0]);

			// stage 3
			u10_q <= csum_add(u0_q, u1_q);
			u11_q <= csum_add(u2_q, u3_q);
			u12_q <= u4_q;
			i10_q <= csum_add(i0_q, i1_q);
			i11_q <= i2_q;

			// stage 4
			u20_q <= csum_add(u10_q, u11_q);
			u21_q <= u12_q;
			i20_q <= csum_add(i10_q, i11_q);

			// stage 5 final sums, inverted
			udp_csum_q <= ~csum_add(u20_q, u21_q);
			ip_csum_q  <= ~i20_q;
		end
	end

	assign beat_o    = beat_q[5];
	assign vld_o     = vld_q[5];
	assign vld_pre_o = vld_q[4];  // next beat one stage behind

	always_comb begin
		hdr_o.ip_ver_tos    = `IPU_VER_TOS;
		hdr_o.ip_total_len  = ilen_q[5];
		hdr_o.ip_ident      = 16'h0000;
		hdr_o.ip_flags_frag = 16'h0000;   // no fragmentation
		hdr_o.ip_ttl_proto  = `IPU_TTL_PROTO;
		hdr_o.ip_csum       = ip_csum_q;
		hdr_o.ip_src        = info_q[5].ip_src;
		hdr_o.ip_dst        = info_q[5].ip_dst;
		hdr_o.port_src      = info_q[5].port_src;
		hdr_o.port_dst      = info_q[5].port_dst;
		hdr_o.udp_len       = ulen_q[5];
		hdr_o.udp_csum      = udp_csum_q;
	end

endmodule

`default_nettype wire

// ==== ip_udp_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ip_udp_config.svh"

// protocol checks on the packer output, bound into ip_udp_packer
module ip_udp_checker (
	input wire logic                   clk,
	input wire logic                   reset_n,
	input wire logic [`IPU_DATA_W-1:0] tdata_i,
	input wire logic [`IPU_KEEP_W-1:0] tkeep_i,
	input wire logic                   tlast_i,
	input wire logic                   tvld_i,
	input wire logic                   rdy_i,
	input wire logic                   user_trdy_i
);

	int fail_cnt = 0; // summed into the testbench result

	// nothing offered on either side while in reset
	a_reset_quiet: assert property (@(posedge clk) !reset_n |-> !tvld_i && !user_trdy_i)
		else begin
			fail_cnt++;
			$error("output valid or input ready high during reset");
		end

	// a stalled word must not change under the sink
	a_hold_stable: assert property (@(posedge clk) disable iff (!reset_n)
		tvld_i && !rdy_i |=> tvld_i && $stable(tdata_i) && $stable(tkeep_i)
			&& $stable(tlast_i))
		else begin
			fail_cnt++;
			$error("output word changed or was withdrawn while stalled");
		end

	a_last_with_valid: assert property (@(posedge clk) disable iff (!reset_n)
		tlast_i |-> tvld_i)
		else begin
			fail_cnt++; // end marker with no word
			$error("tlast high without tvalid");
		end

endmodule

bind ip_udp_packer ip_udp_checker i_ip_udp_checker (
	.clk         (clk),
	.reset_n     (reset_n),
	.tdata_i     (ip_udp_tdata_o),
	.tkeep_i     (ip_udp_tkeep_o),
	.tlast_i     (ip_udp_tlast_o),
	.tvld_i      (ip_udp_tvld_o),
	.rdy_i       (ip_udp_rdy_i),
	.user_trdy_i (user_trdy_o)
);

`default_nettype wire

// ==== ip_udp_config.svh ====
`ifndef IP_UDP_CONFIG_SVH
`define IP_UDP_CONFIG_SVH

// user stream geometry
`define IPU_DATA_W        32
`define IPU_KEEP_W        4    // one enable per byte

// fifo depths as address bits
`define IPU_DATA_AW       10   // payload beats, must hold the longest packet
`define IPU_INFO_AW       4    // packet summaries in flight

// fixed ipv4 header half-words
`define IPU_VER_TOS       16'h4500 // version 4, ihl 5, tos 0
`define IPU_TTL_PROTO     16'h8011 // ttl 128, protocol udp

// protocol number in the udp pseudo-header
`define IPU_PROTO_UDP     8'd17

// header sizes in bytes
`define IPU_IP_HDR_BYTES  20
`define IPU_UDP_HDR_BYTES 8

`endif

// ==== ip_udp_packer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ip_udp_config.svh"

module ip_udp_packer (
	input  wire logic                   clk,
	input  wire logic                   reset_n,
	input  wire logic [31:0]            hdr_ip_src_i,
	input  wire logic [31:0]            hdr_ip_dst_i,
	input  wire logic [15:0]            hdr_port_src_i,
	input  wire logic [15:0]            hdr_port_dst_i,
	input  wire logic [`IPU_DATA_W-1:0] user_tdata_i,
	input  wire logic [`IPU_KEEP_W-1:0] user_tkeep_i,
	input  wire logic                   user_tlast_i,
	input  wire logic                   user_tvld_i,
	output logic                        user_trdy_o,
	output logic [`IPU_DATA_W-1:0]      ip_udp_tdata_o,
	output logic [`IPU_KEEP_W-1:0]      ip_udp_tkeep_o,
	output logic                        ip_udp_tlast_o,
	output logic                        ip_udp_tvld_o,
	input  wire logic                   ip_udp_rdy_i
);

	import ip_udp_pkg::*;

	beat_t       buf_beat;     // buffer to pipe
	pkt_info_t   buf_info;
	logic        buf_vld;
	logic        pipe_adv;
	beat_t       seq_beat;     // pipe to sequencer
	logic        seq_vld;
	logic        seq_vld_pre;
	hdr_fields_t seq_hdr;
	logic        pipe_ready;

	payload_sum_buffer i_payload_sum_buffer (
		.clk            (clk),
		.reset_n        (reset_n),
		.user_tdata_i   (user_tdata_i),
		.user_tkeep_i   (user_tkeep_i),
		.user_tlast_i   (user_tlast_i),
		.user_tvld_i    (user_tvld_i),
		.user_trdy_o    (user_trdy_o),
		.hdr_ip_src_i   (hdr_ip_src_i),
		.hdr_ip_dst_i   (hdr_ip_dst_i),
		.hdr_port_src_i (hdr_port_src_i),
		.hdr_port_dst_i (hdr_port_dst_i),
		.beat_o         (buf_beat),
		.info_o         (buf_info),
		.vld_o          (buf_vld),
		.adv_i          (pipe_adv)
	);

	header_csum_pipe i_header_csum_pipe (
		.clk          (clk),
		.reset_n      (reset_n),
		.beat_i       (buf_beat),
		.info_i       (buf_info),
		.vld_i        (buf_vld),
		.adv_o        (pipe_adv),
		.beat_o       (seq_beat),
		.vld_o        (seq_vld),
		.vld_pre_o    (seq_vld_pre),
		.hdr_o        (seq_hdr),
		.pipe_ready_i (pipe_ready)
	);

	frame_sequencer i_frame_sequencer (
		.clk            (clk),
		.reset_n        (reset_n),
		.beat_i         (seq_beat),
		.vld_i          (seq_vld),
		.vld_pre_i      (seq_vld_pre),
		.hdr_i          (seq_hdr),
		.pipe_ready_o   (pipe_ready),
		.ip_udp_tdata_o (ip_udp_tdata_o),
		.ip_udp_tkeep_o (ip_udp_tkeep_o),
		.ip_udp_tlast_o (ip_udp_tlast_o),
		.ip_udp_tvld_o  (ip_udp_tvld_o),
		.ip_udp_rdy_i   (ip_udp_rdy_i)
	);

endmodule

`default_nettype wire

// ==== ip_udp_pkg.sv ====
`default_nettype none

package ip_udp_pkg;

	`include "ip_udp_config.svh"

	// one user beat, valid bytes packed from the msb
	typedef struct packed {
		logic [`IPU_DATA_W-1:0] data;
		logic [`IPU_KEEP_W-1:0] keep; // keep[3] marks data[31:24]
		logic                   last;
	} beat_t;

	// summary of a buffered packet
	typedef struct packed {
		logic [31:0] ip_src;
		logic [31:0] ip_dst;
		logic [15:0] port_src;
		logic [15:0] port_dst;
		logic [15:0] byte_cnt;  // payload bytes only
		logic [15:0] data_sum;  // folded ones' complement sum of payload
	} pkt_info_t;

	// finished ipv4 + udp header, in wire order
	typedef struct packed {
		logic [15:0] ip_ver_tos;
		logic [15:0] ip_total_len;
		logic [15:0] ip_ident;
		logic [15:0] ip_flags_frag;
		logic [15:0] ip_ttl_proto;
		logic [15:0] ip_csum;
		logic [31:0] ip_src;
		logic [31:0] ip_dst;
		logic [15:0] port_src;
		logic [15:0] port_dst;
		logic [15:0] udp_len;
		logic [15:0] udp_csum;
	} hdr_fields_t;

	// ones' complement add with end-around carry
	function automatic logic [15:0] csum_add(input logic [15:0] a, input logic [15:0] b);
		logic [16:0] s;
		s = {1'b0, a} + {1'b0, b};
		return s[15:0] + {15'd0, s[16]}; // cannot carry again
	endfunction

endpackage

`default_nettype wire

// ==== payload_sum_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ip_udp_config.svh"

module payload_sum_buffer (
	input  wire logic                   clk,
	input  wire logic                   reset_n,
	input  wire logic [`IPU_DATA_W-1:0] user_tdata_i,
	input  wire logic [`IPU_KEEP_W-1:0] user_tkeep_i,
	input  wire logic                   user_tlast_i,
	input  wire logic                   user_tvld_i,
	output logic                        user_trdy_o,
	input  wire logic [31:0]            hdr_ip_src_i,
	input  wire logic [31:0]            hdr_ip_dst_i,
	input  wire logic [15:0]            hdr_port_src_i,
	input  wire logic [15:0]            hdr_port_dst_i,
	output ip_udp_pkg::beat_t           beat_o,
	output ip_udp_pkg::pkt_info_t       info_o,
	output logic                        vld_o,
	input  wire logic                   adv_i
);

	import ip_udp_pkg::*;

	logic                   run_q;       // high from the first clock after reset
	logic                   first_q;     // next accepted beat opens a packet
	logic [15:0]            cnt_q;       // bytes so far
	logic [15:0]            sum_q;       // running payload sum
	logic [31:0]            ip_src_q;
	logic [31:0]            ip_dst_q;
	logic [15:0]            port_src_q;
	logic [15:0]            port_dst_q;
	logic                   in_acc;
	logic [2:0]             beat_bytes;
	logic [`IPU_DATA_W-1:0] data_msk;
	logic [15:0]            cnt_nxt;
	logic [15:0]            sum_nxt;
	beat_t                  beat_in;
	pkt_info_t              info_in;
	logic                   beat_empty, beat_full;
	logic                   info_empty, info_full;
	logic                   pop;

	assign user_trdy_o = run_q && !beat_full && !info_full;
	assign in_acc      = user_tvld_i && user_trdy_o;

	// keep is contiguous, so a plain count of set bits
	assign beat_bytes = 3'(user_tkeep_i[3]) + 3'(user_tkeep_i[2])
		+ 3'(user_tkeep_i[1]) + 3'(user_tkeep_i[0]);

	always_comb begin
		for (int b = 0; b < `IPU_KEEP_W; b++)
			data_msk[8*b +: 8] = user_tdata_i[8*b +: 8] & {8{user_tkeep_i[b]}}; // zero pad
	end

	assign cnt_nxt = cnt_q + 16'(beat_bytes);
	assign sum_nxt = csum_add(csum_add(sum_q, data_msk[31:16]), data_msk[15:0]);

	assign beat_in = '{data: user_tdata_i, keep: user_tkeep_i, last: user_tlast_i};

	// single-beat packet takes its header straight from the ports
	assign info_in.ip_src   = first_q ? hdr_ip_src_i   : ip_src_q;
	assign info_in.ip_dst   = first_q ? hdr_ip_dst_i   : ip_dst_q;
	assign info_in.port_src = first_q ? hdr_port_src_i : port_src_q;
	assign info_in.port_dst = first_q ? hdr_port_dst_i : port_dst_q;
	assign info_in.byte_cnt = cnt_nxt;
	assign info_in.data_sum = sum_nxt;

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			run_q   <= 1'b0;
			first_q <= 1'b1;
			cnt_q   <= '0;
			sum_q   <= '0;
		end else begin
			run_q <= 1'b1;
			if (in_acc) begin
				first_q <= user_tlast_i;
				cnt_q   <= user_tlast_i ? 16'd0 : cnt_nxt; // clear after push
				sum_q   <= user_tlast_i ? 16'd0 : sum_nxt;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (in_acc && first_q) begin // header sampled on the first beat
			ip_src_q   <= hdr_ip_src_i;
			ip_dst_q   <= hdr_ip_dst_i;
			port_src_q <= hdr_port_src_i;
			port_dst_q <= hdr_port_dst_i;
		end
	end

	// release only whole packets
	assign vld_o = !info_empty && !beat_empty;
	assign pop   = adv_i && vld_o;

	sync_fifo #(.T(beat_t), .ADDR_W(`IPU_DATA_AW)) i_beat_fifo (
		.clk       (clk),
		.reset_n   (reset_n),
		.wr_en_i   (in_acc),
		.wr_data_i (beat_in),
		.rd_en_i   (pop),
		.rd_data_o (beat_o),
		.empty_o   (beat_empty),
		.full_o    (beat_full)
	);

	sync_fifo #(.T(pkt_info_t), .ADDR_W(`IPU_INFO_AW)) i_info_fifo (
		.clk       (clk),
		.reset_n   (reset_n),
		.wr_en_i   (in_acc && user_tlast_i),
		.wr_data_i (info_in),
		.rd_en_i   (pop && beat_o.last),   // summary leaves with the last beat
		.rd_data_o (info_o),
		.empty_o   (info_empty),
		.full_o    (info_full)
	);

endmodule

`default_nettype wire

// ==== sync_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

// first-word-fall-through fifo, head entry visible on rd_data_o
module sync_fifo #(
	parameter type T      = logic,
	parameter int  ADDR_W = 4
) (
	input  wire logic clk,
	input  wire logic reset_n,
	input  wire logic wr_en_i,
	input  wire T     wr_data_i,
	input  wire logic rd_en_i,
	output T          rd_data_o,
	output logic      empty_o,
	output logic      full_o
);

	localparam int DEPTH = 2 ** ADDR_W;

	T              mem [DEPTH];
	logic [ADDR_W-1:0] wr_ptr_q;
	logic [ADDR_W-1:0] rd_ptr_q;
	logic [ADDR_W:0]   count_q;   // 0 .. DEPTH
	logic              do_wr;
	logic              do_rd;

	assign do_wr = wr_en_i && !full_o;  // writes into a full fifo are dropped
	assign do_rd = rd_en_i && !empty_o;

	assign empty_o   = (count_q == '0);
	assign full_o    = count_q[ADDR_W];  // top bit only set at DEPTH
	assign rd_data_o = mem[rd_ptr_q];    // no read latency

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr_q] <= wr_data_i;
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (do_wr)
				wr_ptr_q <= wr_ptr_q + 1'b1; // wraps at DEPTH
			if (do_rd)
				rd_ptr_q <= rd_ptr_q + 1'b1;
			case ({do_wr, do_rd})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q; // both or neither
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+.
ip_udp_pkg.sv
sync_fifo.sv
payload_sum_buffer.sv
header_csum_pipe.sv
frame_sequencer.sv
ip_udp_packer.sv
ip_udp_checker.sv
tb_ip_udp_packer.sv

// ==== tb_ip_udp_packer.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ip_udp_packer;

	import ip_udp_pkg::*;

	localparam int CLK_PERIOD = 100;
	localparam int N_PKT      = 84;  // all tests together
	localparam int MAX_WORDS  = 23;  // 64 payload bytes plus seven header words
	localparam int WDOG_CYC   = N_PKT * MAX_WORDS * 20;

	logic        clk;
	logic        reset_n;
	logic [31:0] hdr_ip_src_i;
	logic [31:0] hdr_ip_dst_i;
	logic [15:0] hdr_port_src_i;
	logic [15:0] hdr_port_dst_i;
	logic [31:0] user_tdata_i;
	logic [3:0]  user_tkeep_i;
	logic        user_tlast_i;
	logic        user_tvld_i;
	logic        user_trdy_o;
	logic [31:0] ip_udp_tdata_o;
	logic [3:0]  ip_udp_tkeep_o;
	logic        ip_udp_tlast_o;
	logic        ip_udp_tvld_o;
	logic        ip_udp_rdy_i;

	beat_t       exp_q [$];           // expected output words in order
	logic [15:0] lfsr_q = 16'd19109;
	int          rdy_mode = 0;        // 0 ready, 1 random, 2 held off
	int          errors = 0;
	int          words_seen = 0;
	int          frames_seen = 0;
	int          chk_fails;
	logic        trdy_fell;
	logic [31:0] v;

	ip_udp_packer i_ip_udp_packer (
		.clk            (clk),
		.reset_n        (reset_n),
		.hdr_ip_src_i   (hdr_ip_src_i),
		.hdr_ip_dst_i   (hdr_ip_dst_i),
		.hdr_port_src_i (hdr_port_src_i),
		.hdr_port_dst_i (hdr_port_dst_i),
		.user_tdata_i   (user_tdata_i),
		.user_tkeep_i   (user_tkeep_i),
		.user_tlast_i   (user_tlast_i),
		.user_tvld_i    (user_tvld_i),
		.user_trdy_o    (user_trdy_o),
		.ip_udp_tdata_o (ip_udp_tdata_o),
		.ip_udp_tkeep_o (ip_udp_tkeep_o),
		.ip_udp_tlast_o (ip_udp_tlast_o),
		.ip_udp_tvld_o  (ip_udp_tvld_o),
		.ip_udp_rdy_i   (ip_udp_rdy_i)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] r);
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_step(lfsr_q);  // one step per bit
			r = {r[30:0], lfsr_q[0]};
		end
	endtask

	// fold a wide sum down to 16 bits, carries wrap around
	function automatic logic [15:0] fold_sum(input logic [31:0] s);
		while (s[31:16] != 16'd0)
			s = s[31:16] + s[15:0];
		return s[15:0];
	endfunction

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] want);
		assert (got === want) else begin
			errors++;
			$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, want);
		end
	endtask

	task automatic push_word(input logic [31:0] d, input logic [3:0] k, input logic l);
		exp_q.push_back('{data: d, keep: k, last: l});
	endtask

	// builds the expected frame, then drives the payload beats
	task automatic send_packet(input int len, input int gap_max);
		logic [31:0] words [$];
		logic [3:0]  keeps [$];
		logic [31:0] w, src, dst, ports, junk, g;
		logic [15:0] ulen, ilen;
		logic [31:0] usum, isum;
		logic [7:0]  hi, lo;
		int          nb;
		int          n;
		bit          acc;

		nb = (len + 3) / 4;
		rand_bits(32, src);
		rand_bits(32, dst);
		rand_bits(32, ports);  // source port in the upper half
		for (int i = 0; i < nb; i++) begin
			rand_bits(32, w);    // unused tail bytes stay random
			words.push_back(w);
			n = (len - 4 * i > 4) ? 4 : len - 4 * i;
			keeps.push_back(4'hF << (4 - n)); // bytes packed from the msb
		end
		ulen = 16'(len + 8);
		ilen = 16'(len + 28);

		// ident, flags and the checksum field count as zero
		isum = 32'h4500 + ilen + 32'h8011 + src[31:16] + src[15:0] + dst[31:16] + dst[15:0];
		// pseudo-header, then udp header with zero checksum
		usum = src[31:16] + src[15:0] + dst[31:16] + dst[15:0] + 32'd17 + ulen
			+ ports[31:16] + ports[15:0] + ulen;
		for (int k = 0; k < len; k += 2) begin
			hi = words[k / 4][31 - 8 * (k % 4) -: 8];
			lo = (k + 1 < len) ? words[(k + 1) / 4][31 - 8 * ((k + 1) % 4) -: 8] : 8'h00;
			usum += {hi, lo};   // odd last byte padded low
		end

		push_word({16'h4500, ilen}, 4'hF, 1'b0);
		push_word(32'h0000_0000, 4'hF, 1'b0);
		push_word({16'h8011, ~fold_sum(isum)}, 4'hF, 1'b0);
		push_word(src, 4'hF, 1'b0);
		push_word(dst, 4'hF, 1'b0);
		push_word(ports, 4'hF, 1'b0);
		push_word({ulen, ~fold_sum(usum)}, 4'hF, 1'b0);
		for (int i = 0; i < nb; i++)
			push_word(words[i], keeps[i], i == nb - 1);

		for (int i = 0; i < nb; i++) begin
			if (gap_max > 0) begin
				rand_bits(2, g);
				repeat (int'(g) % (gap_max + 1)) begin
					user_tvld_i = 1'b0;
					@(posedge clk);
					#1;
				end
			end
			rand_bits(32, junk);
			user_tvld_i    = 1'b1;
			user_tdata_i   = words[i];
			user_tkeep_i   = keeps[i];
			user_tlast_i   = (i == nb - 1);
			// header only meaningful on the first beat
			hdr_ip_src_i   = (i == 0) ? src : junk;
			hdr_ip_dst_i   = (i == 0) ? dst : ~junk;
			hdr_port_src_i = (i == 0) ? ports[31:16] : junk[15:0];
			hdr_port_dst_i = (i == 0) ? ports[15:0] : junk[31:16];
			do begin
				@(negedge clk);
				acc = user_trdy_o;  // settled until the next edge
				@(posedge clk);
				#1;
			end while (!acc);
		end
		user_tvld_i  = 1'b0;
		user_tlast_i = 1'b0;
	endtask

	task automatic send_random(input int count, input int gap_max, input int len_bits);
		logic [31:0] r;
		for (int p = 0; p < count; p++) begin
			rand_bits(len_bits, r);
			send_packet(int'(r) + 1, gap_max);
		end
	endtask

	task automatic wait_drain();
		while (exp_q.size() != 0)
			@(posedge clk);
		repeat (2) @(posedge clk);
		#1;
	endtask

	task automatic apply_reset(input int cycles);
		reset_n = 1'b0;
		repeat (cycles) begin
			@(negedge clk);
			check_val("ip_udp_tvld_o", ip_udp_tvld_o, 32'd0);
			check_val("user_trdy_o", user_trdy_o, 32'd0);
			@(posedge clk);
			#1;
		end
		reset_n = 1'b1;
		@(negedge clk);
		check_val("ip_udp_tvld_o", ip_udp_tvld_o, 32'd0);  // right after release
		@(negedge clk);
		check_val("user_trdy_o", user_trdy_o, 32'd1);      // up after the first clock
		@(posedge clk);
		#1;
	endtask

	task automatic check_word();
		beat_t want;
		if (exp_q.size() == 0) begin
			errors++;
			$display("Output word %h at %0t arrived with no frame expected", ip_udp_tdata_o, $time);
		end else begin
			want = exp_q.pop_front();
			check_val("ip_udp_tdata_o", ip_udp_tdata_o, want.data);
			check_val("ip_udp_tkeep_o", ip_udp_tkeep_o, want.keep);
			check_val("ip_udp_tlast_o", ip_udp_tlast_o, want.last);
			words_seen++;
			if (want.last)
				frames_seen++;
		end
	endtask

	// scoreboard, transfer happens on the coming edge
	always @(negedge clk) begin
		if (reset_n && ip_udp_tvld_o && ip_udp_rdy_i)
			check_word();
	end

	// output sink ready, random bits drawn on the falling edge
	initial begin
		ip_udp_rdy_i = 1'b0;
		forever begin
			@(negedge clk);
			if (rdy_mode == 1)
				rand_bits(2, v);
			@(posedge clk);
			#1;
			case (rdy_mode)
				0: ip_udp_rdy_i = 1'b1;
				1: ip_udp_rdy_i = (v[1:0] != 2'd0);  // about three in four
				default: ip_udp_rdy_i = 1'b0;
			endcase
		end
	end

	initial begin
		#(longint'(WDOG_CYC) * CLK_PERIOD);
		$display("Timeout: output stream did not drain within %0d cycles", WDOG_CYC);
		$display("*** FAILED ***");
		$finish;
	end

	initial begin
		user_tdata_i   = '0;
		user_tkeep_i   = '0;
		user_tlast_i   = 1'b0;
		user_tvld_i    = 1'b0;
		hdr_ip_src_i   = '0;
		hdr_ip_dst_i   = '0;
		hdr_port_src_i = '0;
		hdr_port_dst_i = '0;
		apply_reset(10);

		// 1: whole-word payload
		send_packet(16, 0);
		wait_drain();

		// 2: one, two and three bytes in the last beat, single beat too
		send_packet(13, 0);
		send_packet(14, 0);
		send_packet(15, 0);
		send_packet(1, 0);
		wait_drain();

		// 3: back to back, no input gaps
		send_random(6, 0, 6);
		wait_drain();

		// 4: input gaps, random sink ready
		rdy_mode = 1;
		send_random(40, 3, 6);
		wait_drain();

		// 5: sink held off until the input side backs up
		rdy_mode  = 2;
		trdy_fell = 1'b0;
		fork
			send_random(30, 0, 4);
			begin
				while (!trdy_fell) begin
					@(negedge clk);
					if (!user_trdy_o)
						trdy_fell = 1'b1;
				end
				repeat (20) @(posedge clk);
				rdy_mode = 0;
			end
		join
		wait_drain();

		// 6: reset with a frame stuck inside, then a clean restart
		rdy_mode = 2;
		send_packet(20, 0);
		repeat (10) @(posedge clk);
		#1;
		apply_reset(4);
		exp_q.delete();  // stuck frame is gone
		rdy_mode = 0;
		send_packet(9, 0);
		send_packet(32, 1);
		wait_drain();

		chk_fails = i_ip_udp_packer.i_ip_udp_checker.fail_cnt;
		$display("words %0d, frames %0d, mismatches %0d, assertion failures %0d",
			words_seen, frames_seen, errors, chk_fails);
		if (errors == 0 && chk_fails == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire
